// File: hw/emem_config.svh
`ifndef EMEM_CONFIG_SVH
`define EMEM_CONFIG_SVH

// Index width of the 64-bit storage array, 64K double words
`define EMEM_MAW 16

// Mesh packet width in bits
`define EMEM_PW 104

// Built-in wait generator
// 0 leaves back-pressure to wait_in alone
`define EMEM_THROTTLE 0

// Throttle opens for one cycle in every 2**EMEM_THROTTLE_LOG
`define EMEM_THROTTLE_LOG 6

`endif

// File: hw/emem_pkg.sv
`include "emem_config.svh"

package emem_pkg;

   // Mesh field widths
   typedef logic [31:0] emem_addr_t;
   typedef logic [31:0] emem_data_t;
   typedef logic [4:0]  emem_ctrl_t;
   typedef logic [1:0]  emem_mode_t;

   // Storage side widths
   typedef logic [63:0]             emem_dword_t;
   typedef logic [7:0]              emem_wen_t;
   typedef logic [`EMEM_MAW-1:0]    emem_index_t;

   // Data mode codes
   localparam emem_mode_t DM_BYTE   = 2'd0;
   localparam emem_mode_t DM_SHORT  = 2'd1;
   localparam emem_mode_t DM_WORD   = 2'd2;
   localparam emem_mode_t DM_DOUBLE = 2'd3;

   // Mesh transaction, most significant field first
   typedef struct packed {
      emem_addr_t srcaddr;
      emem_data_t data;
      emem_addr_t dstaddr;
      emem_ctrl_t ctrlmode;
      emem_mode_t datamode;
      logic       write;
   } emem_packet_t;

   // One access to the storage array
   typedef struct packed {
      logic        en;
      emem_wen_t   wen;
      emem_index_t index;
      emem_dword_t wdata;
   } emem_mem_req_t;

   // What the reply path needs to remember about a read
   typedef struct packed {
      logic       valid;
      emem_mode_t datamode;
      emem_ctrl_t ctrlmode;
      logic [2:0] lane;
      emem_addr_t reply_addr;
   } emem_rd_ctx_t;

endpackage

// File: hw/emem_decode.sv
`timescale 1ns/100ps
`include "emem_config.svh"

module emem_decode
(
   input  logic                    clk,
   input  logic                    nreset,
   input  logic                    access_in,
   input  emem_pkg::emem_packet_t  packet_in,
   input  logic                    wait_in,
   output logic                    wait_out,
   output emem_pkg::emem_mem_req_t mem_req,
   output emem_pkg::emem_rd_ctx_t  rd_ctx
);

   logic                 wait_thr;
   logic                 accept;
   logic [2:0]           lane;
   emem_pkg::emem_data_t word;
   emem_pkg::emem_wen_t  lane_wen;
   emem_pkg::emem_wen_t  wen_low;

   // Optional throttle, open only when the counter wraps to zero
   generate
      if (`EMEM_THROTTLE != 0)
      begin : g_throttle
         logic [`EMEM_THROTTLE_LOG-1:0] thr_cnt;

         always_ff @(posedge clk or negedge nreset)
         begin
            if (!nreset)
               thr_cnt <= '0;
            else
               thr_cnt <= thr_cnt + 1'b1;
         end

         assign wait_thr = |thr_cnt;
      end
      else
      begin : g_no_throttle
         assign wait_thr = 1'b0;
      end
   endgenerate

   assign wait_out = wait_in | wait_thr;
   assign accept   = access_in & ~wait_out;
   assign lane     = packet_in.dstaddr[2:0];

   // Narrow writes are replicated so every lane sees its bytes
   always_comb
   begin
      case (packet_in.datamode)
         emem_pkg::DM_BYTE:  word = {4{packet_in.data[7:0]}};
         emem_pkg::DM_SHORT: word = {2{packet_in.data[15:0]}};
         default:            word = packet_in.data;
      endcase
   end

   // Byte lanes aligned to the access size
   always_comb
   begin
      case (packet_in.datamode)
         emem_pkg::DM_BYTE:  lane_wen = 8'h01 << lane;
         emem_pkg::DM_SHORT: lane_wen = 8'h03 << {lane[2:1], 1'b0};
         emem_pkg::DM_WORD:  lane_wen = 8'h0f << {lane[2], 2'b00};
         default:            lane_wen = 8'hff;
      endcase
   end

   assign mem_req.en    = accept;
   assign mem_req.wen   = (accept & packet_in.write) ? lane_wen : '0;
   assign mem_req.index = packet_in.dstaddr[`EMEM_MAW+2:3];
   // Double writes carry their upper word in srcaddr
   assign mem_req.wdata = (packet_in.datamode == emem_pkg::DM_DOUBLE) ?
                          {packet_in.srcaddr, word} : {word, word};

   assign rd_ctx.valid      = accept & ~packet_in.write;
   assign rd_ctx.datamode   = packet_in.datamode;
   assign rd_ctx.ctrlmode   = packet_in.ctrlmode;
   assign rd_ctx.lane       = lane;
   assign rd_ctx.reply_addr = packet_in.srcaddr;

   // Lowest set lane, used to test the enables for a single run
   assign wen_low = mem_req.wen & (~mem_req.wen + 8'd1);

   a_wen_shape: assert property (
      @(posedge clk) disable iff (!nreset)
      (mem_req.wen != '0) |->
         ($countones(mem_req.wen) inside {1, 2, 4, 8}) &&
         (((mem_req.wen + wen_low) & mem_req.wen) == '0)
   ) else $error("write enables are not a single aligned run");

endmodule

// File: hw/emem_array.sv
`timescale 1ns/100ps
`include "emem_config.svh"

module emem_array
(
   input  logic                    clk,
   input  emem_pkg::emem_mem_req_t mem_req,
   output emem_pkg::emem_dword_t   rdata
);

   localparam int DEPTH = 2 ** `EMEM_MAW;

   // 64-bit rows, one per double word of address space
   emem_pkg::emem_dword_t mem [0:DEPTH-1];

   // Read returns the old row, writes land at the same edge
   always_ff @(posedge clk)
   begin
      if (mem_req.en)
      begin
         rdata <= mem[mem_req.index];
      end
   end

   // Byte lane writes
   always_ff @(posedge clk)
   begin
      if (mem_req.en)
      begin
         for (int i = 0; i < 8; i++)
         begin
            if (mem_req.wen[i])
               mem[mem_req.index][8*i +: 8] <= mem_req.wdata[8*i +: 8];
         end
      end
   end

endmodule

// File: hw/emem_result.sv
`timescale 1ns/100ps

module emem_result
(
   input  logic                   clk,
   input  logic                   nreset,
   input  emem_pkg::emem_rd_ctx_t rd_ctx,
   input  emem_pkg::emem_dword_t  rdata,
   output logic                   access_out,
   output emem_pkg::emem_packet_t packet_out
);

   emem_pkg::emem_rd_ctx_t ctx_q;
   emem_pkg::emem_data_t   field;

   // Context of the request accepted last cycle
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         ctx_q <= '0;
      else
         ctx_q <= rd_ctx;
   end

   // Reply strobe follows an accepted read by one cycle
   assign access_out = ctx_q.valid;

   // Pull the addressed field down to bit 0
   always_comb
   begin
      case (ctx_q.datamode)
         emem_pkg::DM_BYTE:
            field = {24'b0, rdata[8*ctx_q.lane +: 8]};
         emem_pkg::DM_SHORT:
            field = {16'b0, rdata[16*ctx_q.lane[2:1] +: 16]};
         emem_pkg::DM_WORD:
            field = ctx_q.lane[2] ? rdata[63:32] : rdata[31:0];
         default:
            field = rdata[31:0];
      endcase
   end

   // Reply goes back to the requester as a write
   always_comb
   begin
      packet_out.write    = 1'b1;
      packet_out.datamode = ctx_q.datamode;
      packet_out.ctrlmode = ctx_q.ctrlmode;
      packet_out.dstaddr  = ctx_q.reply_addr;
      packet_out.data     = field;
      // Upper word of a double rides in srcaddr
      if (ctx_q.datamode == emem_pkg::DM_DOUBLE)
         packet_out.srcaddr = rdata[63:32];
      else
         packet_out.srcaddr = '0;
   end

   // Reply must be a write built from a known row
   a_reply_shape: assert property (
      @(posedge clk) disable iff (!nreset)
      access_out |->
         packet_out.write && !$isunknown(packet_out)
   ) else $error("reply packet is not a known write");

endmodule

// File: hw/emem_top.sv
`timescale 1ns/100ps
`include "emem_config.svh"

module emem_top
(
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   access_in,
   input  emem_pkg::emem_packet_t packet_in,
   input  logic                   wait_in,
   output logic                   wait_out,
   output logic                   access_out,
   output emem_pkg::emem_packet_t packet_out
);

   emem_pkg::emem_mem_req_t mem_req;
   emem_pkg::emem_rd_ctx_t  rd_ctx;
   emem_pkg::emem_dword_t   rdata;

   // Packet layout has to agree with the configured mesh width
   generate
      if ($bits(emem_pkg::emem_packet_t) != `EMEM_PW)
      begin : g_pw_check
         $error("packet struct width differs from EMEM_PW");
      end
   endgenerate

   // Unpack, address and back-pressure
   emem_decode u_decode
   (
      .clk       (clk),
      .nreset    (nreset),
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_in   (wait_in),
      .wait_out  (wait_out),
      .mem_req   (mem_req),
      .rd_ctx    (rd_ctx)
   );

   emem_array u_array
   (
      .clk     (clk),
      .mem_req (mem_req),
      .rdata   (rdata)
   );

   // Read-back alignment and reply
   emem_result u_result
   (
      .clk        (clk),
      .nreset     (nreset),
      .rd_ctx     (rd_ctx),
      .rdata      (rdata),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// File: bench/emem_tb.sv
`timescale 1ns/100ps
`include "emem_config.svh"

module emem_tb;

   localparam int MAX_LINES = 64;
   localparam int N_COLS    = 7;
   localparam int RAND_ROWS = 16;
   localparam int N_RAND    = 80;
   localparam logic [31:0] RAND_BASE = 32'h0000_1000;

   // Expected reply and the cycle it has to show up in
   typedef struct packed {
      int                     cycle;
      emem_pkg::emem_packet_t pkt;
   } reply_t;

   logic                   clk;
   logic                   nreset;
   logic                   access_in;
   emem_pkg::emem_packet_t packet_in;
   logic                   wait_in;
   logic                   wait_out;
   logic                   access_out;
   emem_pkg::emem_packet_t packet_out;

   logic [31:0] pat_mem [0:MAX_LINES*N_COLS-1];
   // Byte model of the low 8 KB of the address space
   logic [7:0]  model_mem [0:8191];
   reply_t      replies [$];
   reply_t      head;
   int          n_lines;
   int          cyc_count;
   int          cycle_limit;
   int          n_checks;
   int          n_errors;
   logic [31:0] rand_state;

   emem_top uut
   (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cyc_count <= cyc_count + 1;
      if (cyc_count >= cycle_limit)
      begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return {rand_state[15:0], rand_state[31:16]};
   endfunction

   // Access covers 1 << mode bytes, address aligned down to that size
   function automatic logic [63:0] model_read(input logic [1:0] mode, input logic [31:0] addr);
      logic [12:0] base;
      logic [63:0] val;
      base = addr[12:0] & ~((13'd1 << mode) - 13'd1);
      val  = '0;
      for (int i = 0; i < (1 << mode); i++)
         val[8*i +: 8] = model_mem[base + 13'(i)];
      return val;
   endfunction

   function automatic void model_write(input logic [1:0] mode, input logic [31:0] addr,
                                       input logic [63:0] val);
      logic [12:0] base;
      base = addr[12:0] & ~((13'd1 << mode) - 13'd1);
      for (int i = 0; i < (1 << mode); i++)
         model_mem[base + 13'(i)] = val[8*i +: 8];
   endfunction

   task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                              input string what);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("FAIL %0t: %s (got %0h, expected %0h)", $time, what, got, exp);
      end
   endtask

   // One request; held until taken unless it is meant to meet wait_in
   task automatic issue_op(input logic write, input logic [1:0] mode, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] src, input logic hold,
                           input logic [4:0] ctrl, output logic [63:0] pred);
      emem_pkg::emem_packet_t pkt;
      reply_t                 rep;
      pkt.srcaddr  = src;
      pkt.data     = data;
      pkt.dstaddr  = addr;
      pkt.ctrlmode = ctrl;
      pkt.datamode = mode;
      pkt.write    = write;
      pred         = model_read(mode, addr);
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= pkt;
      wait_in   <= hold;
      @(negedge clk);
      if (`EMEM_THROTTLE == 0)
         check_value(128'(wait_out), 128'(hold), "wait_out follows wait_in");
      if (hold)
         check_value(128'(wait_out), 128'(1'b1), "wait_out under wait_in");
      else
      begin
         while (wait_out)
            @(negedge clk);
         if (write)
            model_write(mode, addr, {src, data});
         else
         begin
            rep.cycle        = cyc_count + 1;
            rep.pkt.write    = 1'b1;
            rep.pkt.datamode = mode;
            rep.pkt.ctrlmode = ctrl;
            rep.pkt.dstaddr  = src;
            rep.pkt.data     = pred[31:0];
            rep.pkt.srcaddr  = pred[63:32];
            replies.push_back(rep);
         end
      end
   endtask

   task automatic run_pattern(input int n);
      logic [31:0] op;
      logic [31:0] mode;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] hi;
      logic [31:0] hold;
      logic [31:0] exp_lo;
      logic [63:0] pred;
      op     = pat_mem[n*N_COLS];
      mode   = pat_mem[n*N_COLS + 1];
      addr   = pat_mem[n*N_COLS + 2];
      data   = pat_mem[n*N_COLS + 3];
      hi     = pat_mem[n*N_COLS + 4];
      hold   = pat_mem[n*N_COLS + 5];
      exp_lo = pat_mem[n*N_COLS + 6];
      if (op[0])
         issue_op(1'b1, mode[1:0], addr, data, hi, hold[0], n[4:0], pred);
      else
      begin
         // Reads carry their reply address in the data column
         issue_op(1'b0, mode[1:0], addr, 32'h0, data, hold[0], n[4:0], pred);
         if (!hold[0])
            check_value(128'({hi, exp_lo}), 128'(pred), "pattern value vs model");
      end
   endtask

   // Each reply must match the oldest outstanding read
   always @(negedge clk)
   begin
      if (nreset && access_out)
      begin
         if (replies.size() == 0)
         begin
            n_errors++;
            $display("Error at %0t: reply seen without an accepted read", $time);
         end
         else
         begin
            head = replies.pop_front();
            check_value(128'(cyc_count), 128'(head.cycle), "reply cycle");
            check_value(128'(packet_out), 128'(head.pkt), "reply packet");
         end
      end
   end

   initial
   begin
      logic [63:0] pred;
      logic [31:0] rnd;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] whi;
      clk         = 1'b0;
      nreset      = 1'b0;
      access_in   = 1'b0;
      packet_in   = '0;
      wait_in     = 1'b0;
      cyc_count   = 0;
      n_checks    = 0;
      n_errors    = 0;
      rand_state  = 32'd48264;
      for (int i = 0; i < MAX_LINES*N_COLS; i++)
         pat_mem[i] = '1;
      $readmemh("bench/emem_patterns.txt", pat_mem);
      n_lines = 0;
      while (n_lines < MAX_LINES && pat_mem[n_lines*N_COLS] != 32'hffff_ffff)
         n_lines++;
      cycle_limit = 4 * (n_lines + RAND_ROWS + N_RAND) + 100;

      repeat (10) @(posedge clk);
      nreset <= 1'b1;
      @(negedge clk);
      check_value(128'(access_out), 128'(1'b0), "access_out after reset");
      if (`EMEM_THROTTLE == 0)
         check_value(128'(wait_out), 128'(1'b0), "wait_out after reset");

      for (int n = 0; n < n_lines; n++)
         run_pattern(n);

      // Known contents first, so random reads never hit empty bytes
      for (int r = 0; r < RAND_ROWS; r++)
      begin
         wdata = next_rand();
         whi   = next_rand();
         issue_op(1'b1, emem_pkg::DM_DOUBLE, RAND_BASE + 32'(8*r), wdata, whi,
                  1'b0, 5'd0, pred);
      end
      for (int k = 0; k < N_RAND; k++)
      begin
         rnd   = next_rand();
         addr  = RAND_BASE + (next_rand() % 32'(8*RAND_ROWS));
         wdata = next_rand();
         whi   = next_rand();
         issue_op(rnd[0], rnd[2:1], addr, wdata, whi, rnd[5:3] == 3'd0, rnd[10:6], pred);
      end

      @(posedge clk);
      access_in <= 1'b0;
      wait_in   <= 1'b0;
      repeat (4) @(negedge clk);
      check_value(128'(replies.size()), 128'(0), "replies still outstanding");
      $display("Checks: %0d  Errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: bench/emem_patterns.txt
// op (1 write, 0 read)  mode (0 byte, 1 short, 2 word, 3 double)  address  data  high  wait_in  expected
// Reads: data is the reply address, high is the expected upper word, expected is the data field
1 3 00000000 33221100 77665544 0 00000000
0 3 00000000 A0000001 77665544 0 33221100
// Byte lanes on row 0x08
1 3 00000008 00000000 00000000 0 00000000
1 0 00000008 CCCCCC10 00000000 0 00000000
0 3 00000008 A0000002 00000000 0 00000010
1 0 0000000B CCCCCC13 00000000 0 00000000
0 3 00000008 A0000003 00000000 0 13000010
1 0 0000000D CCCCCC15 00000000 0 00000000
0 3 00000008 A0000004 00001500 0 13000010
1 0 0000000E CCCCCC16 00000000 0 00000000
0 3 00000008 A0000005 00161500 0 13000010
1 0 00000009 CCCCCC11 00000000 0 00000000
1 0 0000000A CCCCCC12 00000000 0 00000000
1 0 0000000C CCCCCC14 00000000 0 00000000
1 0 0000000F CCCCCC17 00000000 0 00000000
0 3 00000008 A0000006 17161514 0 13121110
// Narrow reads of row 0x08
0 0 0000000D A0000007 00000000 0 00000015
0 1 0000000E A0000008 00000000 0 00001716
0 2 0000000C A0000009 00000000 0 17161514
0 2 00000008 A000000A 00000000 0 13121110
0 0 0000000A A000000B 00000000 0 00000012
0 1 0000000B A000000C 00000000 0 00001312
// Short lanes on row 0x10
1 3 00000010 FFFFFFFF FFFFFFFF 0 00000000
1 1 00000010 1234ABCD 00000000 0 00000000
0 3 00000010 A000000D FFFFFFFF 0 FFFFABCD
1 1 00000017 00005566 00000000 0 00000000
0 3 00000010 A000000E 5566FFFF 0 FFFFABCD
1 1 00000012 00007788 00000000 0 00000000
1 1 00000014 000099AA 00000000 0 00000000
0 3 00000010 A000000F 556699AA 0 7788ABCD
// Word lanes on row 0x18
1 3 00000018 11111111 22222222 0 00000000
1 2 0000001C CAFEF00D 00000000 0 00000000
0 3 00000018 A0000010 CAFEF00D 0 11111111
1 2 0000001A 0BADBEEF 00000000 0 00000000
0 3 00000018 A0000011 CAFEF00D 0 0BADBEEF
0 2 0000001D A0000012 00000000 0 CAFEF00D
// Requests under wait_in are dropped
1 3 00000000 DEADDEAD DEADDEAD 1 00000000
0 3 00000000 A0000013 00000000 1 00000000
0 3 00000000 A0000014 77665544 0 33221100
1 0 00000008 000000EE 00000000 1 00000000
0 0 00000008 A0000015 00000000 0 00000010

// File: list.f
+incdir+hw
hw/emem_pkg.sv
hw/emem_decode.sv
hw/emem_array.sv
hw/emem_result.sv
hw/emem_top.sv
bench/emem_tb.sv

// File: Makefile
TOP = emem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
